//--- build.f
+incdir+include
hw/sdram_pkg.sv
hw/sdram_bank_if.sv
hw/sdram_req_stage.sv
hw/sdram_bank.sv
hw/sdram_cmd_arb.sv
hw/sdram_rd_capture.sv
hw/sdram_ctrl_top.sv
verification/sdram_ctrl_assert.sv
verification/tb_sdram_checker.sv
verification/tb_sdram_top.sv

//--- Makefile
# Verilator build and run of the sdram controller testbench
# run from the project root, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_sdram_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/sdram_cases.txt
# name  op(W=write R=read)  addr(hex {bank,row,col})  data(hex write data or expected read)
# unwritten words read back addr[15:0] ^ addr[22:16]
wr_b0_first W 000A10 1234
rd_b0_same R 000A10 1234
wr_b0_hit W 000A11 5A5A
rd_b0_hit R 000A11 5A5A
wr_b1_first W 415630 BEEF
rd_b0_alt R 000A10 1234
rd_b1_alt R 415630 BEEF
wr_b0_miss W 024620 C0DE
rd_b0_miss R 000A11 5A5A
rd_b0_back R 024620 C0DE
rd_b1_fill R 415631 5670
wr_b1_top W 7FFFFF 0F0F
rd_b1_top R 7FFFFF 0F0F

//--- verification/tb_sdram_top.sv
/*
 * testbench top, run from the project root so the case file is found
 * memory model starts ready, unwritten words read addr[15:0] ^ addr[22:16]
 * client holds req a random 0..5 cycles after ack to exercise back-pressure
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;   // released off the edge
    end
endmodule

module tb_sdram_top;

    localparam int    NAME_W      = 128;   // 16 characters
    localparam int    CASE_CYCLES = 200;   // watchdog budget per case
    localparam string CASE_FILE   = "verification/sdram_cases.txt";

    logic                     clk, rst;
    logic                     req, we, ack, dq_oe;
    logic [`SDRAM_AW-1:0]     addr;
    logic [`SDRAM_DATA_W-1:0] wdata, rdata, dq_out, dq_in;
    logic                     cs_n, ras_n, cas_n, we_n, ba;
    logic [`SDRAM_ROW_W-1:0]  a;
    logic [NAME_W-1:0]        cur_name;
    logic [`SDRAM_DATA_W-1:0] cur_exp;
    int                       chk_errors;
    int                       tb_errors;
    int                       seed;
    logic                     cases_loaded;

    logic [NAME_W-1:0]        c_name [$];
    logic                     c_we   [$];
    logic [`SDRAM_AW-1:0]     c_addr [$];
    logic [`SDRAM_DATA_W-1:0] c_data [$];

    tb_clk_gen #(.PERIOD(20), .RST_CYCLES(3)) i_clk (.clk, .rst);

    sdram_ctrl_top i_dut (
        .clk, .rst, .req, .addr, .we, .wdata, .ack, .rdata,
        .cs_n, .ras_n, .cas_n, .we_n, .ba, .a, .dq_out, .dq_oe, .dq_in
    );

    tb_sdram_checker #(.NAME_W(NAME_W)) i_chk (
        .clk, .rst, .req, .addr, .we, .ack, .rdata, .cs_n, .ras_n, .cas_n, .we_n,
        .case_name(cur_name), .case_exp(cur_exp), .errors(chk_errors)
    );

    // memory model, decodes the pins one edge after the controller drives them
    logic [3:0]               pin_cmd;
    logic [`SDRAM_ROW_W-1:0]  mdl_row [`SDRAM_BANKS];
    logic [`SDRAM_DATA_W-1:0] mem [logic [`SDRAM_AW-1:0]];
    logic [`SDRAM_DATA_W-1:0] rd_pipe [`SDRAM_CL];
    logic [`SDRAM_AW-1:0]     mdl_addr;

    assign pin_cmd  = {cs_n, ras_n, cas_n, we_n};
    assign mdl_addr = {ba, mdl_row[ba], a[`SDRAM_COL_W-1:0]};
    assign dq_in    = rd_pipe[`SDRAM_CL-1];   // on dq from CL cycles after READ

    function automatic logic [`SDRAM_DATA_W-1:0] read_word(input logic [`SDRAM_AW-1:0] adr);
        if (mem.exists(adr))
            return mem[adr];
        return adr[`SDRAM_DATA_W-1:0] ^ `SDRAM_DATA_W'(adr >> `SDRAM_DATA_W);
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SDRAM_CL; i++)
                rd_pipe[i] <= '0;
        end else begin
            if (pin_cmd == sdram_pkg::ACTIVE)
                mdl_row[ba] <= a;
            if (pin_cmd == sdram_pkg::WRITE && dq_oe)
                mem[mdl_addr] = dq_out;
            rd_pipe[0] <= (pin_cmd == sdram_pkg::READ) ? read_word(mdl_addr) : '0;
            for (int i = 1; i < `SDRAM_CL; i++)
                rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    task automatic load_cases();
        int                       fd;
        int                       n;
        string                    line;
        logic [NAME_W-1:0]        nm;
        logic [7:0]               op;
        logic [`SDRAM_AW-1:0]     ad;
        logic [`SDRAM_DATA_W-1:0] dt;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %0s", CASE_FILE);
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin   // skip comment lines
                if ($sscanf(line, "%s %s %h %h", nm, op, ad, dt) == 4) begin
                    if (op != "W" && op != "R") begin
                        $display("unknown operation in case file line: %0s", line);
                        tb_errors++;
                    end else begin
                        c_name.push_back(nm);
                        c_we.push_back(op == "W");
                        c_addr.push_back(ad);
                        c_data.push_back(dt);
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // one four-phase access, outputs are looked at 1 ns after the edge
    task automatic run_case(input int k);
        int hold;
        @(posedge clk);
        #1;
        cur_name = c_name[k];
        cur_exp  = c_data[k];
        addr     = c_addr[k];
        we       = c_we[k];
        wdata    = c_we[k] ? c_data[k] : '0;
        req      = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        hold = {$random(seed)} % 6;   // keep req up a while after ack
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (ack);
    endtask

    initial begin : main
        req          = 1'b0;
        addr         = '0;
        we           = 1'b0;
        wdata        = '0;
        cur_name     = '0;
        cur_exp      = '0;
        seed         = 74711;
        tb_errors    = 0;
        cases_loaded = 1'b0;
        load_cases();
        cases_loaded = 1'b1;
        if (c_addr.size() == 0) begin
            $display("no cases were read from the case file");
            tb_errors++;
        end
        wait (!rst);
        repeat (5) @(posedge clk);   // idle stretch, pins must stay NOP
        for (int k = 0; k < c_addr.size(); k++)
            run_case(k);
        repeat (4) @(posedge clk);   // let the checker close the last access
        #1;
        i_chk.report(tb_errors);
        if (chk_errors + tb_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (cases_loaded);
        limit = c_addr.size() * CASE_CYCLES + 50;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- verification/tb_sdram_checker.sv
/*
 * transaction checker on the client port and the command pins
 * keeps its own open-row table and predicts PRECHARGE / ACTIVE per access
 * one access in flight, commands are counted from req rise to ack fall
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module tb_sdram_checker #(
    parameter int NAME_W = 128
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [`SDRAM_AW-1:0]     addr,
    input  logic                     we,
    input  logic                     ack,
    input  logic [`SDRAM_DATA_W-1:0] rdata,
    input  logic                     cs_n,
    input  logic                     ras_n,
    input  logic                     cas_n,
    input  logic                     we_n,
    input  logic [NAME_W-1:0]        case_name,
    input  logic [`SDRAM_DATA_W-1:0] case_exp,
    output int                       errors
);

    logic [3:0]               pin_cmd;
    int                       data_err;
    int                       cmd_err;
    int                       proto_err;
    logic                     seen_req;   // first req has come
    logic                     busy;       // access in flight
    logic                     acked;
    logic                     req_q;
    logic                     is_rd;
    int                       n_act, n_pre, n_rd, n_wr;
    int                       exp_act, exp_pre;
    logic                     open_vld [`SDRAM_BANKS];
    logic [`SDRAM_ROW_W-1:0]  open_row [`SDRAM_BANKS];
    logic [`SDRAM_DATA_W-1:0] rdata_hold;
    logic [NAME_W-1:0]        name_q;
    logic [`SDRAM_DATA_W-1:0] exp_q;
    logic                     bank_x;
    logic [`SDRAM_ROW_W-1:0]  row_x;

    assign pin_cmd = {cs_n, ras_n, cas_n, we_n};
    assign errors  = data_err + cmd_err + proto_err;

    task automatic check_count(input string what, input int exp_n, input int act_n);
        if (exp_n != act_n) begin
            $display("[ERROR] %0s: %0s expected %0d actual %0d", name_q, what, exp_n, act_n);
            cmd_err++;
        end
    endtask

    task automatic report(input int other);
        $display("errors: data %0d, command counts %0d, protocol %0d, testbench %0d",
                 data_err, cmd_err, proto_err, other);
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            data_err = 0;
            cmd_err = 0;
            proto_err = 0;
            seen_req = 1'b0;
            busy = 1'b0;
            acked = 1'b0;
            req_q = 1'b0;
            is_rd = 1'b0;
            for (int b = 0; b < `SDRAM_BANKS; b++)
                open_vld[b] = 1'b0;   // controller starts with all banks closed
        end else begin
            if (!seen_req && !req) begin   // quiet pins until the first access
                if (pin_cmd != sdram_pkg::NOP) begin
                    $display("a command was issued before the first request");
                    proto_err++;
                end
                if (ack) begin
                    $display("ack went high before the first request");
                    proto_err++;
                end
            end
            if (busy) begin
                if (pin_cmd == sdram_pkg::ACTIVE) n_act++;
                if (pin_cmd == sdram_pkg::PRECHARGE) n_pre++;
                if (pin_cmd == sdram_pkg::READ) n_rd++;
                if (pin_cmd == sdram_pkg::WRITE) n_wr++;
                if (ack && !acked) begin
                    acked = 1'b1;
                    rdata_hold = rdata;
                    if (is_rd && rdata !== exp_q) begin
                        $display("[ERROR] %0s: read data expected %h actual %h",
                                 name_q, exp_q, rdata);
                        data_err++;
                    end
                end else if (ack && acked) begin
                    if (rdata !== rdata_hold) begin   // back-pressure, must hold
                        $display("[ERROR] %0s: held rdata expected %h actual %h",
                                 name_q, rdata_hold, rdata);
                        data_err++;
                    end
                end else if (!ack && acked) begin
                    if (req_q) begin
                        $display("%0s: ack dropped while req was still high", name_q);
                        proto_err++;
                    end
                    check_count("PRECHARGE count", exp_pre, n_pre);
                    check_count("ACTIVE count", exp_act, n_act);
                    check_count("READ count", int'(is_rd), n_rd);
                    check_count("WRITE count", int'(!is_rd), n_wr);
                    busy = 1'b0;
                end
            end else if (ack) begin
                $display("ack is high with no access in flight");
                proto_err++;
            end
            if (req && !req_q && !busy) begin   // new access
                bank_x = addr[`SDRAM_AW-1];
                row_x  = addr[`SDRAM_AW-2 -: `SDRAM_ROW_W];
                if (!open_vld[bank_x]) begin
                    exp_act = 1;   // closed bank, open it
                    exp_pre = 0;
                end else if (open_row[bank_x] == row_x) begin
                    exp_act = 0;   // hit
                    exp_pre = 0;
                end else begin
                    exp_act = 1;   // miss, close then open
                    exp_pre = 1;
                end
                open_vld[bank_x] = 1'b1;
                open_row[bank_x] = row_x;
                busy = 1'b1;
                acked = 1'b0;
                seen_req = 1'b1;
                is_rd = !we;
                name_q = case_name;
                exp_q = case_exp;
                n_act = 0;
                n_pre = 0;
                n_rd = 0;
                n_wr = 0;
            end
            req_q = req;
        end
    end

endmodule

//--- verification/sdram_ctrl_assert.sv
/*
 * pin and handshake assertions, bound into the controller top
 * gaps are counted in clk cycles between commands seen on the pins
 * gap counters saturate at 15, long gaps all read as large
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_ctrl_assert (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic cs_n,
    input logic ras_n,
    input logic cas_n,
    input logic we_n,
    input logic ba
);

    localparam logic [3:0] SAT = 4'd15;

    logic [3:0] cmd;
    logic [3:0] since_act;                     // any bank
    logic [3:0] since_act_bk [`SDRAM_BANKS];   // per bank, for tRCD
    logic [3:0] since_pre_bk [`SDRAM_BANKS];   // per bank, for tRP

    assign cmd = {cs_n, ras_n, cas_n, we_n};

    function automatic logic [3:0] bump(input logic [3:0] v);
        return (v == SAT) ? SAT : v + 4'd1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            since_act <= SAT;
            for (int b = 0; b < `SDRAM_BANKS; b++) begin
                since_act_bk[b] <= SAT;
                since_pre_bk[b] <= SAT;
            end
        end else begin
            since_act <= (cmd == sdram_pkg::ACTIVE) ? 4'd1 : bump(since_act);
            for (int b = 0; b < `SDRAM_BANKS; b++) begin
                if (cmd == sdram_pkg::ACTIVE && int'(ba) == b)
                    since_act_bk[b] <= 4'd1;
                else
                    since_act_bk[b] <= bump(since_act_bk[b]);
                if (cmd == sdram_pkg::PRECHARGE && int'(ba) == b)
                    since_pre_bk[b] <= 4'd1;
                else
                    since_pre_bk[b] <= bump(since_pre_bk[b]);
            end
        end
    end

    // ack is registered, so req is checked one sample back
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req)) else $error("ack rose while req was low");

    act_to_act: assert property (@(posedge clk) disable iff (rst)
        (cmd == sdram_pkg::ACTIVE) |-> (int'(since_act) >= `SDRAM_TRRD))
        else $error("two ACTIVE commands closer than tRRD");

    act_to_access: assert property (@(posedge clk) disable iff (rst)
        (cmd == sdram_pkg::READ || cmd == sdram_pkg::WRITE)
        |-> (int'(since_act_bk[ba]) >= `SDRAM_TRCD))
        else $error("READ or WRITE within tRCD of the ACTIVE of its bank");

    pre_to_act: assert property (@(posedge clk) disable iff (rst)
        (cmd == sdram_pkg::ACTIVE) |-> (int'(since_pre_bk[ba]) >= `SDRAM_TRP))
        else $error("ACTIVE within tRP of the PRECHARGE of its bank");

endmodule

bind sdram_ctrl_top sdram_ctrl_assert i_assert (
    .clk, .rst, .req, .ack, .cs_n, .ras_n, .cas_n, .we_n, .ba
);

//--- hw/sdram_ctrl_top.sv
/*
 * sdram controller top, two banks, single-word accesses
 * no refresh and no init sequence, memory is taken as ready after reset
 * dq is split into dq_out / dq_oe / dq_in, tristate lives outside
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_ctrl_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [`SDRAM_AW-1:0]     addr,
    input  logic                     we,
    input  logic [`SDRAM_DATA_W-1:0] wdata,
    output logic                     ack,
    output logic [`SDRAM_DATA_W-1:0] rdata,
    output logic                     cs_n,
    output logic                     ras_n,
    output logic                     cas_n,
    output logic                     we_n,
    output logic                     ba,
    output logic [`SDRAM_ROW_W-1:0]  a,
    output logic [`SDRAM_DATA_W-1:0] dq_out,
    output logic                     dq_oe,
    input  logic [`SDRAM_DATA_W-1:0] dq_in
);

    sdram_pkg::access_t       acc;
    logic [`SDRAM_BANKS-1:0]  start;
    logic [`SDRAM_BANKS-1:0]  done;
    logic                     rd_issued;
    logic                     rd_valid;
    logic [`SDRAM_DATA_W-1:0] rd_data;

    sdram_bank_if bif0 ();
    sdram_bank_if bif1 ();

    sdram_req_stage i_req (
        .clk, .rst, .req, .addr, .we, .wdata, .ack, .rdata,
        .acc, .start, .done, .rd_valid, .rd_data
    );

    sdram_bank i_bank0 (
        .clk, .rst, .acc, .start(start[0]), .done(done[0]), .bif(bif0)
    );

    sdram_bank i_bank1 (
        .clk, .rst, .acc, .start(start[1]), .done(done[1]), .bif(bif1)
    );

    sdram_cmd_arb i_arb (
        .clk, .rst, .bif0, .bif1, .cs_n, .ras_n, .cas_n, .we_n,
        .ba, .a, .dq_out, .dq_oe, .rd_issued, .wdata(acc.wdata)
    );

    sdram_rd_capture i_cap (
        .clk, .rst, .rd_issued, .dq(dq_in), .rd_valid, .rd_data
    );

endmodule

//--- hw/sdram_rd_capture.sv
/*
 * read return path
 * dq must carry the read word in the cycle that starts CL clocks
 * after READ shows on the pins; rd_valid follows CL+1 clocks after READ
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_rd_capture (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_issued,
    input  logic [`SDRAM_DATA_W-1:0] dq,
    output logic                     rd_valid,
    output logic [`SDRAM_DATA_W-1:0] rd_data
);

    localparam int CL = `SDRAM_CL;

    logic [CL:0] pipe;   // one bit per cycle since READ, top bit is rd_valid

    assign rd_valid = pipe[CL];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pipe <= '0;
        else
            pipe <= {pipe[CL-1:0], rd_issued};
    end

    // word is due while pipe[CL-1] is set
    always_ff @(posedge clk) begin
        if (pipe[CL-1])
            rd_data <= dq;
    end

endmodule

//--- hw/sdram_cmd_arb.sv
/*
 * fixed priority arbiter, bank 0 first, one command per cycle
 * pins are registered, NOP whenever no bank is granted
 * an ACTIVE waits while the tRRD window of the last ACTIVE is open
 * wdata must be valid when a WRITE is granted
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_cmd_arb (
    input  logic                     clk,
    input  logic                     rst,
    sdram_bank_if.arb                bif0,
    sdram_bank_if.arb                bif1,
    output logic                     cs_n,
    output logic                     ras_n,
    output logic                     cas_n,
    output logic                     we_n,
    output logic                     ba,
    output logic [`SDRAM_ROW_W-1:0]  a,
    output logic [`SDRAM_DATA_W-1:0] dq_out,
    output logic                     dq_oe,
    output logic                     rd_issued,
    input  logic [`SDRAM_DATA_W-1:0] wdata
);

    logic [3:0]              rrd_cnt;   // cycles left in the tRRD window
    logic                    act_ok;
    logic                    ok0, ok1;
    sdram_pkg::sdram_cmd_e   sel_cmd;
    logic                    sel_ba;
    logic [`SDRAM_ROW_W-1:0] sel_a;

    assign act_ok = (rrd_cnt == '0);
    assign ok0 = bif0.want && (bif0.cmd != sdram_pkg::ACTIVE || act_ok);
    assign ok1 = bif1.want && (bif1.cmd != sdram_pkg::ACTIVE || act_ok);

    assign bif0.grant = ok0;
    assign bif1.grant = ok1 && !ok0;   // bank 1 only when bank 0 is quiet

    always_comb begin
        sel_cmd = sdram_pkg::NOP;
        sel_ba  = 1'b0;
        sel_a   = '0;
        if (ok0) begin
            sel_cmd = bif0.cmd;
            sel_a   = (bif0.cmd == sdram_pkg::ACTIVE) ? bif0.row : `SDRAM_ROW_W'(bif0.col);
        end else if (ok1) begin
            sel_cmd = bif1.cmd;
            sel_ba  = 1'b1;
            sel_a   = (bif1.cmd == sdram_pkg::ACTIVE) ? bif1.row : `SDRAM_ROW_W'(bif1.col);
        end
        // column path leaves a[10] low: no auto-precharge, single-bank PRECHARGE
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {cs_n, ras_n, cas_n, we_n} <= sdram_pkg::NOP;
            ba        <= 1'b0;
            a         <= '0;
            dq_oe     <= 1'b0;
            rd_issued <= 1'b0;
            rrd_cnt   <= '0;
        end else begin
            {cs_n, ras_n, cas_n, we_n} <= sel_cmd;
            dq_oe     <= (sel_cmd == sdram_pkg::WRITE);
            rd_issued <= (sel_cmd == sdram_pkg::READ);   // starts the capture delay
            if (ok0 || ok1) begin
                ba <= sel_ba;
                a  <= sel_a;
            end
            if (sel_cmd == sdram_pkg::ACTIVE)
                rrd_cnt <= 4'(`SDRAM_TRRD - 1);
            else if (rrd_cnt != '0)
                rrd_cnt <= rrd_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_cmd == sdram_pkg::WRITE)
            dq_out <= wdata;   // same edge as the WRITE pins
    end

endmodule

//--- hw/sdram_bank.sv
/*
 * open-row machine for one bank, row stays open after every access
 * hit: access only; miss: PRECHARGE, ACTIVE, access; closed: ACTIVE, access
 * tRP and tRCD count from the granted edge, arbiter may add more delay
 * start is only taken in IDLE_CLOSED or OPEN
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_bank (
    input  logic                clk,
    input  logic                rst,
    input  sdram_pkg::access_t  acc,
    input  logic                start,
    output logic                done,
    sdram_bank_if.bank          bif
);

    localparam int CNT_W = 4;

    sdram_pkg::bank_st_e     st;
    sdram_pkg::sdram_cmd_e   cmd_q;
    logic                    want_q;
    logic [CNT_W-1:0]        cnt;       // tRP / tRCD wait
    logic [`SDRAM_ROW_W-1:0] open_row;
    logic [`SDRAM_ROW_W-1:0] row_q;
    logic [`SDRAM_COL_W-1:0] col_q;
    logic                    we_q;
    logic                    row_hit;

    assign row_hit = (acc.row == open_row);   // only meaningful in OPEN

    assign bif.want = want_q;
    assign bif.cmd  = cmd_q;
    assign bif.row  = row_q;
    assign bif.col  = col_q;

    assign done = bif.grant && (st == sdram_pkg::ISSUE);   // read/write accepted

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st     <= sdram_pkg::IDLE_CLOSED;
            cmd_q  <= sdram_pkg::NOP;
            want_q <= 1'b0;
            cnt    <= '0;
        end else begin
            case (st)
                sdram_pkg::IDLE_CLOSED: if (start) begin
                    want_q <= 1'b1;
                    cmd_q  <= sdram_pkg::ACTIVE;
                    st     <= sdram_pkg::ACT_WAIT;
                end
                sdram_pkg::OPEN: if (start) begin
                    want_q <= 1'b1;
                    if (row_hit) begin
                        cmd_q <= acc.we ? sdram_pkg::WRITE : sdram_pkg::READ;
                        st    <= sdram_pkg::ISSUE;
                    end else begin
                        cmd_q <= sdram_pkg::PRECHARGE;   // wrong row open
                        st    <= sdram_pkg::PRECH_WAIT;
                    end
                end
                sdram_pkg::PRECH_WAIT: begin
                    if (want_q) begin
                        if (bif.grant) begin
                            want_q <= 1'b0;
                            cnt    <= CNT_W'(`SDRAM_TRP - 1);
                        end
                    end else if (cnt <= 1) begin   // ask one cycle ahead of the slot
                        want_q <= 1'b1;
                        cmd_q  <= sdram_pkg::ACTIVE;
                        st     <= sdram_pkg::ACT_WAIT;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                sdram_pkg::ACT_WAIT: begin
                    if (want_q) begin
                        if (bif.grant) begin
                            want_q <= 1'b0;
                            cnt    <= CNT_W'(`SDRAM_TRCD - 1);
                        end
                    end else if (cnt <= 1) begin
                        want_q <= 1'b1;
                        cmd_q  <= we_q ? sdram_pkg::WRITE : sdram_pkg::READ;
                        st     <= sdram_pkg::ISSUE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: if (bif.grant) begin   // ISSUE
                    want_q <= 1'b0;
                    cmd_q  <= sdram_pkg::NOP;
                    st     <= sdram_pkg::OPEN;   // leave the row open
                end
            endcase
        end
    end

    // request fields and the open row
    always_ff @(posedge clk) begin
        if (start) begin
            row_q <= acc.row;
            col_q <= acc.col;
            we_q  <= acc.we;
        end
        if (st == sdram_pkg::ACT_WAIT && want_q && bif.grant)
            open_row <= row_q;   // row is open from this ACTIVE on
    end

endmodule

//--- hw/sdram_req_stage.sv
/*
 * four-phase client port, one access in flight
 * client holds addr/we/wdata while req is high
 * ack: write issued, or read data on rdata; held until req drops
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_req_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [`SDRAM_AW-1:0]     addr,
    input  logic                     we,
    input  logic [`SDRAM_DATA_W-1:0] wdata,
    output logic                     ack,
    output logic [`SDRAM_DATA_W-1:0] rdata,
    output sdram_pkg::access_t       acc,
    output logic [`SDRAM_BANKS-1:0]  start,
    input  logic [`SDRAM_BANKS-1:0]  done,
    input  logic                     rd_valid,
    input  logic [`SDRAM_DATA_W-1:0] rd_data
);

    typedef enum logic [1:0] {RQ_IDLE, RQ_WAIT_CMD, RQ_WAIT_RD, RQ_ACK} rq_st_e;

    rq_st_e st;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= RQ_IDLE;
            ack   <= 1'b0;
            start <= '0;
        end else begin
            start <= '0;   // one-cycle pulse
            case (st)
                RQ_IDLE: if (req) begin
                    start[addr[`SDRAM_AW-1]] <= 1'b1;   // top bit picks the bank
                    st <= RQ_WAIT_CMD;
                end
                RQ_WAIT_CMD: if (|done) begin
                    if (acc.we) begin
                        ack <= 1'b1;   // write is done once issued
                        st  <= RQ_ACK;
                    end else begin
                        st <= RQ_WAIT_RD;
                    end
                end
                RQ_WAIT_RD: if (rd_valid) begin
                    ack <= 1'b1;
                    st  <= RQ_ACK;
                end
                default: if (!req) begin   // hold until client lets go
                    ack <= 1'b0;
                    st  <= RQ_IDLE;
                end
            endcase
        end
    end

    // payload, captured on the accepted req and on returning read data
    always_ff @(posedge clk) begin
        if (st == RQ_IDLE && req) begin
            {acc.bank, acc.row, acc.col} <= addr;
            acc.we    <= we;
            acc.wdata <= wdata;
        end
        if (st == RQ_WAIT_RD && rd_valid)
            rdata <= rd_data;
    end

endmodule

//--- hw/sdram_bank_if.sv
/*
 * command request path from one bank machine to the arbiter
 * the bank holds want, cmd, row and col steady until grant
 * grant is combinational and lasts one cycle
 */
`timescale 1ns/1ps
`include "sdram_params.svh"

interface sdram_bank_if;

    logic                    want;   // bank has a command pending
    sdram_pkg::sdram_cmd_e   cmd;
    logic [`SDRAM_ROW_W-1:0] row;    // used by ACTIVE
    logic [`SDRAM_COL_W-1:0] col;    // used by READ / WRITE
    logic                    grant;  // command goes to the pins next edge

    modport bank (
        output want, cmd, row, col,
        input  grant
    );

    modport arb (
        input  want, cmd, row, col,
        output grant
    );

endinterface

//--- hw/sdram_pkg.sv
/*
 * shared types of the sdram controller
 * command values are the raw {cs_n, ras_n, cas_n, we_n} pin levels
 * access_t carries one single-word request, 40 bits with default params
 */
`include "sdram_params.svh"

package sdram_pkg;

    // pins /CS /RAS /CAS /WE
    typedef enum logic [3:0] {
        NOP       = 4'b0111,
        ACTIVE    = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010    // a[10] low, one bank only
    } sdram_cmd_e;

    typedef struct packed {
        logic                     bank;   // two banks only
        logic [`SDRAM_ROW_W-1:0]  row;
        logic [`SDRAM_COL_W-1:0]  col;
        logic                     we;     // 1 = write
        logic [`SDRAM_DATA_W-1:0] wdata;
    } access_t;

    // open-row machine, one per bank
    typedef enum logic [2:0] {
        IDLE_CLOSED,   // no row open
        OPEN,          // row held open, waiting for work
        PRECH_WAIT,    // precharge asked or tRP running
        ACT_WAIT,      // active asked or tRCD running
        ISSUE          // read/write asked
    } bank_st_e;

endpackage

//--- include/sdram_params.svh
/*
 * geometry and timing of the sdram controller
 * timing values are in clk cycles, all must be 1 or more
 * client address is {bank, row, col}, so AW = 1 + ROW_W + COL_W
 */
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

`define SDRAM_ROW_W  13     // row address, also width of the a pins
`define SDRAM_COL_W  9      // column, goes on a[8:0]
`define SDRAM_BANKS  2      // bank machines in the controller
`define SDRAM_DATA_W 16     // dq width
`define SDRAM_AW     23     // bank bit + row + col

`define SDRAM_TRP    2      // precharge to active
`define SDRAM_TRCD   2      // active to read/write
`define SDRAM_TRRD   2      // active to active, any bank
`define SDRAM_CL     2      // cas latency

`endif
